/* include/a1_consts.svh */
// core constants
`ifndef A1_CONSTS_SVH
`define A1_CONSTS_SVH

// sys_clock is cpu x 7 x 8
`define A1_PIXEL_DIV 8

// cpu tick every 7 pixel ticks
`define A1_CPU_DIV 56

// low system ram
`define A1_LOW_RAM_BASE 'h0000
`define A1_LOW_RAM_SIZE 16384

// basic ram
`define A1_BASIC_BASE 'hE000
`define A1_BASIC_SIZE 4096

// monitor rom written by the downloader only
`define A1_MONITOR_BASE 'hFF00
`define A1_MONITOR_SIZE 256

// cpu ticks the cpu stays in reset after a reset event
`define A1_RESET_TICKS 2

`endif

/* verilog/a1_pkg.sv */
// core bus and state types
package a1_pkg;

	// one cpu or download address in a 64k space
	typedef logic [15:0] a1_addr_t;

	// one data byte on the memory bus
	typedef logic [7:0] a1_data_t;

	// power-up and boot sequencing
	typedef enum logic [2:0] {
		ST_WAIT_LOCK, // waiting for the pll
		ST_WAIT_ROM,  // pll ok and boot rom not started
		ST_LOADING,   // downloader busy
		ST_RESET,     // cpu held in reset for a few cpu ticks
		ST_RUN        // cpu running
	} a1_boot_state_e;

	// decoded memory regions
	typedef enum logic [1:0] {
		REG_NONE,     // unmapped and reads as zero
		REG_LOW_RAM,  // 0x0000 to 0x3fff
		REG_BASIC,    // 0xe000 to 0xefff
		REG_MONITOR   // 0xff00 to 0xffff and written by the loader only
	} a1_region_e;

endpackage

/* verilog/a1_mem_if.sv */
// memory bus access
`timescale 1ns/1ps

interface a1_mem_if;
	import a1_pkg::*;

	a1_addr_t addr;      // cpu or download address
	a1_data_t wdata;     // write byte
	logic     wr;        // write on every edge while high
	logic     by_loader; // access belongs to the downloader
	a1_data_t rdata;     // read byte one cycle after addr

	// bus owner side
	modport arbiter (
		output addr, wdata, wr, by_loader,
		input  rdata
	);

	// decoder and memories
	modport memory (
		input  addr, wdata, wr, by_loader,
		output rdata
	);

endinterface

/* verilog/a1_sync_ram.sv */
// single-port synchronous byte ram
`timescale 1ns/1ps

module a1_sync_ram #(
	parameter int DEPTH = 256 // bytes as a power of two
) (
	input  logic                     sys_clock,
	input  logic [$clog2(DEPTH)-1:0] addr,
	input  logic                     wr,
	input  a1_pkg::a1_data_t         wdata,
	output a1_pkg::a1_data_t         rdata
);
	import a1_pkg::*;

	a1_data_t mem_q [DEPTH]; // byte storage

	always_ff @(posedge sys_clock) begin
		if (wr) begin
			mem_q[addr] <= wdata;
		end
		rdata <= mem_q[addr]; // old data on a write cycle
	end

endmodule

/* verilog/a1_clock_enables.sv */
// pixel and cpu clock enables
`timescale 1ns/1ps
`include "a1_consts.svh"

module a1_clock_enables (
	input  logic sys_clock,
	input  logic arst_n,
	output logic pixel_clken,
	output logic cpu_clken
);

	localparam int PIX_W     = $clog2(`A1_PIXEL_DIV);
	localparam int CPU_RATIO = `A1_CPU_DIV / `A1_PIXEL_DIV; // pixel ticks per cpu tick
	localparam int RATIO_W   = $clog2(CPU_RATIO);

	logic [PIX_W-1:0]   pix_cnt;   // sys cycles within one pixel
	logic [RATIO_W-1:0] ratio_cnt; // pixel ticks within one cpu tick
	logic               pix_wrap;
	logic               cpu_wrap;

	assign pix_wrap = (pix_cnt == PIX_W'(`A1_PIXEL_DIV - 1));
	assign cpu_wrap = pix_wrap && (ratio_cnt == RATIO_W'(CPU_RATIO - 1)); // only on a pixel wrap

	always_ff @(posedge sys_clock or negedge arst_n) begin
		if (!arst_n) begin
			pix_cnt     <= '0;
			ratio_cnt   <= '0;
			pixel_clken <= 1'b0;
			cpu_clken   <= 1'b0;
		end else begin
			pix_cnt <= pix_wrap ? '0 : pix_cnt + 1'b1;
			if (pix_wrap) begin
				ratio_cnt <= cpu_wrap ? '0 : ratio_cnt + 1'b1;
			end
			// registered so the first pulse lands exactly DIV cycles after reset
			pixel_clken <= pix_wrap;
			cpu_clken   <= cpu_wrap;
		end
	end

	// a cpu tick sits on a pixel tick that ends a full pixel period
	a_cpu_on_pixel: assert property (
		@(posedge sys_clock) disable iff (!arst_n)
		cpu_clken |-> pixel_clken && $past(pixel_clken, `A1_PIXEL_DIV)
	);

endmodule

/* verilog/a1_boot_fsm.sv */
// boot and reset sequencer
`timescale 1ns/1ps
`include "a1_consts.svh"

module a1_boot_fsm (
	input  logic sys_clock,
	input  logic arst_n,
	input  logic pll_locked,
	input  logic dl_active,
	input  logic reset_request,
	input  logic reset_key,
	input  logic cpu_clken,
	output logic cpu_reset,
	output logic rom_loaded
);
	import a1_pkg::*;

	localparam int TICK_W = $clog2(`A1_RESET_TICKS + 1);

	a1_boot_state_e    state;
	logic              dl_active_q;  // previous dl_active
	logic              reset_key_q;  // previous reset_key
	logic [TICK_W-1:0] tick_cnt;     // cpu ticks seen in ST_RESET
	logic              dl_fall;
	logic              key_rise;
	logic              last_tick;

	assign dl_fall   = dl_active_q && !dl_active;   // download finished
	assign key_rise  = reset_key && !reset_key_q;   // held key resets once
	assign last_tick = cpu_clken && (tick_cnt == TICK_W'(`A1_RESET_TICKS - 1));

	always_ff @(posedge sys_clock or negedge arst_n) begin
		if (!arst_n) begin
			state       <= ST_WAIT_LOCK;
			dl_active_q <= 1'b0;
			reset_key_q <= 1'b0;
			tick_cnt    <= '0;
			rom_loaded  <= 1'b0;
		end else begin
			dl_active_q <= dl_active;
			reset_key_q <= reset_key;
			unique case (state)
				ST_WAIT_LOCK: if (pll_locked) state <= ST_WAIT_ROM;
				ST_WAIT_ROM:  if (dl_active) state <= ST_LOADING;
				ST_LOADING: begin
					if (dl_fall) begin
						rom_loaded <= 1'b1; // sticky from here on
						tick_cnt   <= '0;
						state      <= ST_RESET;
					end
				end
				ST_RESET: begin
					if (reset_request) begin
						tick_cnt <= '0; // restart the count after release
					end else if (last_tick) begin
						state <= ST_RUN;
					end else if (cpu_clken) begin
						tick_cnt <= tick_cnt + 1'b1;
					end
				end
				ST_RUN: begin
					// downloads while running leave the state alone
					if (!pll_locked) begin
						tick_cnt <= '0;
						state    <= rom_loaded ? ST_RESET : ST_WAIT_LOCK;
					end else if (reset_request || key_rise) begin
						tick_cnt <= '0;
						state    <= ST_RESET;
					end
				end
				default: state <= ST_WAIT_LOCK;
			endcase
		end
	end

	assign cpu_reset = (state != ST_RUN); // held in every state but run

	// the cpu only runs once the boot rom is in
	a_run_needs_rom: assert property (
		@(posedge sys_clock) disable iff (!arst_n)
		!cpu_reset |-> rom_loaded
	);

endmodule

/* verilog/a1_bus_arbiter.sv */
// download versus cpu bus arbiter
`timescale 1ns/1ps

module a1_bus_arbiter (
	input  logic             dl_active,
	input  logic             dl_wr,
	input  logic             cpu_wr,
	input  a1_pkg::a1_addr_t dl_addr,
	input  a1_pkg::a1_addr_t cpu_addr,
	input  a1_pkg::a1_data_t dl_data,
	input  a1_pkg::a1_data_t cpu_dout,
	output a1_pkg::a1_data_t bus_dout,
	output logic             led,
	a1_mem_if.arbiter        mem
);

	logic dl_win; // downloader owns this cycle

	assign dl_win = dl_active && dl_wr;

	always_comb begin
		if (dl_win) begin
			mem.addr      = dl_addr;
			mem.wdata     = dl_data;
			mem.wr        = 1'b1;
			mem.by_loader = 1'b1;
		end else begin
			// cpu write lost if it collides with a download
			mem.addr      = cpu_addr;
			mem.wdata     = cpu_dout;
			mem.wr        = cpu_wr;
			mem.by_loader = 1'b0;
		end
	end

	assign bus_dout = mem.rdata; // read data back to the cpu
	assign led      = !dl_win;   // blinks off on download writes

endmodule

/* verilog/a1_memory_map.sv */
// address decoder and on-chip memories
`timescale 1ns/1ps
`include "a1_consts.svh"

module a1_memory_map (
	input  logic      sys_clock,
	a1_mem_if.memory  mem
);
	import a1_pkg::*;

	localparam int LOW_AW   = $clog2(`A1_LOW_RAM_SIZE);
	localparam int BASIC_AW = $clog2(`A1_BASIC_SIZE);
	localparam int MON_AW   = $clog2(`A1_MONITOR_SIZE);

	a1_region_e region;   // region of the current address
	a1_region_e region_q; // region of the data now on the ram outputs
	logic       low_we;
	logic       basic_we;
	logic       mon_we;
	a1_data_t   low_dout;
	a1_data_t   basic_dout;
	a1_data_t   mon_dout;

	function automatic logic in_window(input a1_addr_t a, input int base, input int size);
		return (int'(a) >= base) && (int'(a) < base + size);
	endfunction

	always_comb begin
		if (in_window(mem.addr, `A1_LOW_RAM_BASE, `A1_LOW_RAM_SIZE)) region = REG_LOW_RAM;
		else if (in_window(mem.addr, `A1_BASIC_BASE, `A1_BASIC_SIZE)) region = REG_BASIC;
		else if (in_window(mem.addr, `A1_MONITOR_BASE, `A1_MONITOR_SIZE)) region = REG_MONITOR;
		else region = REG_NONE;
	end

	assign low_we   = mem.wr && (region == REG_LOW_RAM);
	assign basic_we = mem.wr && (region == REG_BASIC);
	assign mon_we   = mem.wr && mem.by_loader && (region == REG_MONITOR); // rom to the cpu

	// match the one-cycle ram latency
	always_ff @(posedge sys_clock) begin
		region_q <= region;
	end

	// bases are size aligned, so low bits index each ram
	a1_sync_ram #(.DEPTH(`A1_LOW_RAM_SIZE)) u_low_ram (
		.sys_clock (sys_clock),
		.addr      (mem.addr[LOW_AW-1:0]),
		.wr        (low_we),
		.wdata     (mem.wdata),
		.rdata     (low_dout)
	);

	a1_sync_ram #(.DEPTH(`A1_BASIC_SIZE)) u_basic (
		.sys_clock (sys_clock),
		.addr      (mem.addr[BASIC_AW-1:0]),
		.wr        (basic_we),
		.wdata     (mem.wdata),
		.rdata     (basic_dout)
	);

	a1_sync_ram #(.DEPTH(`A1_MONITOR_SIZE)) u_monitor (
		.sys_clock (sys_clock),
		.addr      (mem.addr[MON_AW-1:0]),
		.wr        (mon_we),
		.wdata     (mem.wdata),
		.rdata     (mon_dout)
	);

	always_comb begin
		unique case (region_q)
			REG_LOW_RAM: mem.rdata = low_dout;
			REG_BASIC:   mem.rdata = basic_dout;
			REG_MONITOR: mem.rdata = mon_dout;
			default:     mem.rdata = '0; // unmapped reads as zero
		endcase
	end

	// an unmapped address reads back zero on the next cycle
	a_hole_reads_zero: assert property (
		@(posedge sys_clock) (region == REG_NONE) |=> (mem.rdata == '0)
	);

endmodule

/* verilog/a1_top.sv */
// memory and control core
`timescale 1ns/1ps

module a1_top (
	input  logic             sys_clock,
	input  logic             arst_n,
	input  logic             pll_locked,
	input  logic             reset_request,
	input  logic             reset_key,
	input  logic             dl_active,
	input  logic             dl_wr,
	input  logic             cpu_wr,
	input  a1_pkg::a1_addr_t dl_addr,
	input  a1_pkg::a1_addr_t cpu_addr,
	input  a1_pkg::a1_data_t dl_data,
	input  a1_pkg::a1_data_t cpu_dout,
	output a1_pkg::a1_data_t bus_dout,
	output logic             cpu_clken,
	output logic             pixel_clken,
	output logic             cpu_reset,
	output logic             rom_loaded,
	output logic             led
);

	a1_mem_if u_mem ();

	a1_clock_enables u_clock_enables (
		.sys_clock   (sys_clock),
		.arst_n      (arst_n),
		.pixel_clken (pixel_clken),
		.cpu_clken   (cpu_clken)
	);

	// holds the cpu until the monitor rom is in
	a1_boot_fsm u_boot_fsm (
		.sys_clock     (sys_clock),
		.arst_n        (arst_n),
		.pll_locked    (pll_locked),
		.dl_active     (dl_active),
		.reset_request (reset_request),
		.reset_key     (reset_key),
		.cpu_clken     (cpu_clken),
		.cpu_reset     (cpu_reset),
		.rom_loaded    (rom_loaded)
	);

	a1_bus_arbiter u_bus_arbiter (
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.cpu_wr    (cpu_wr),
		.dl_addr   (dl_addr),
		.cpu_addr  (cpu_addr),
		.dl_data   (dl_data),
		.cpu_dout  (cpu_dout),
		.bus_dout  (bus_dout),
		.led       (led),
		.mem       (u_mem.arbiter)
	);

	a1_memory_map u_memory_map (
		.sys_clock (sys_clock),
		.mem       (u_mem.memory)
	);

endmodule

/* sim/a1_tb.sv */
// core testbench
`timescale 1ns/1ps
`include "a1_consts.svh"

module a1_tb;
	import a1_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int BUDGET     = 10 + 200 + 1000 + 500 + 50 + 1300; // cycle budgets of tests 1 to 6

	logic     sys_clock, arst_n, pll_locked, reset_request, reset_key;
	logic     dl_active, dl_wr, cpu_wr;
	a1_addr_t dl_addr, cpu_addr;
	a1_data_t dl_data, cpu_dout, bus_dout;
	logic     cpu_clken, pixel_clken, cpu_reset, rom_loaded, led;

	a1_data_t model [65536]; // reference memory image
	a1_data_t exp_q [$];     // expected read bytes in issue order
	a1_addr_t rd_addr_q [$];
	a1_addr_t written_q [$]; // every address written so far
	logic     rd_issue;      // a read address goes out this cycle
	logic     rd_due;        // its data is on bus_dout now
	int       cycle;         // cycles since reset release
	int       errors, tests, failed_tests;

	a1_top u_dut (.*);

	initial begin
		sys_clock = 1'b0;
		forever #(CLK_PERIOD / 2) sys_clock = ~sys_clock;
	end

	always @(posedge sys_clock or negedge arst_n) begin
		if (!arst_n) cycle <= 0;
		else cycle <= cycle + 1;
	end

	always @(posedge sys_clock) rd_due <= rd_issue; // one cycle read latency

	// compare read data at the falling edge where it is stable
	always @(negedge sys_clock) begin : compare_reads
		a1_data_t exp_byte;
		a1_addr_t exp_addr;
		if (rd_due) begin
			exp_byte = exp_q.pop_front();
			exp_addr = rd_addr_q.pop_front();
			check_data(bus_dout, exp_byte, $sformatf("read of %04h", exp_addr));
		end
	end

	function automatic a1_region_e region_of(input a1_addr_t a);
		int ia = int'(a);
		if (ia >= `A1_LOW_RAM_BASE && ia < `A1_LOW_RAM_BASE + `A1_LOW_RAM_SIZE) return REG_LOW_RAM;
		if (ia >= `A1_BASIC_BASE && ia < `A1_BASIC_BASE + `A1_BASIC_SIZE) return REG_BASIC;
		if (ia >= `A1_MONITOR_BASE && ia < `A1_MONITOR_BASE + `A1_MONITOR_SIZE) return REG_MONITOR;
		return REG_NONE;
	endfunction

	function automatic a1_data_t expected_read(input a1_addr_t a);
		return (region_of(a) == REG_NONE) ? '0 : model[a]; // holes read as zero
	endfunction

	task automatic check_data(input a1_data_t actual, input a1_data_t expected, input string msg);
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED at %0t: %s, expected %02h, got %02h", $time, msg, expected, actual);
		end
	endtask

	task automatic check_flag(input logic actual, input logic expected, input string msg);
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED at %0t: %s, expected %b, got %b", $time, msg, expected, actual);
		end
	endtask

	task automatic check_count(input int actual, input int expected, input string msg);
		if (actual != expected) begin
			errors++;
			$display("CHECK FAILED at %0t: %s, expected %0d, got %0d", $time, msg, expected, actual);
		end
	endtask

	// one cpu bus cycle that reads when wr is low
	task automatic cpu_cycle(input a1_addr_t a, input a1_data_t d, input logic wr);
		@(posedge sys_clock);
		cpu_addr <= a;
		cpu_dout <= d;
		cpu_wr   <= wr;
		dl_wr    <= 1'b0;
		rd_issue <= !wr;
		if (wr) begin
			written_q.push_back(a);
			if (region_of(a) == REG_LOW_RAM || region_of(a) == REG_BASIC) model[a] = d; // not monitor
		end else begin
			exp_q.push_back(expected_read(a));
			rd_addr_q.push_back(a);
		end
	endtask

	task automatic dl_cycle(input a1_addr_t a, input a1_data_t d);
		@(posedge sys_clock);
		dl_addr  <= a;
		dl_data  <= d;
		dl_wr    <= 1'b1;
		cpu_wr   <= 1'b0;
		rd_issue <= 1'b0;
		written_q.push_back(a);
		if (region_of(a) != REG_NONE) model[a] = d; // loader may write every region
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge sys_clock);
			cpu_wr   <= 1'b0;
			dl_wr    <= 1'b0;
			rd_issue <= 1'b0;
		end
	endtask

	task automatic read_back(input int first);
		for (int i = first; i < written_q.size(); i++) cpu_cycle(written_q[i], '0, 1'b0);
		idle(2); // let the last compare happen
	endtask

	// call at a falling edge
	task automatic wait_cpu_reset(input logic level, input int limit);
		int n = 0;
		while (cpu_reset !== level && n < limit) begin
			@(negedge sys_clock);
			n++;
		end
		if (cpu_reset !== level) begin
			errors++;
			$display("cpu_reset never went to %b within %0d cycles", level, limit);
		end
	endtask

	// from a falling edge inside a reset, count cpu ticks until the cpu runs
	task automatic measure_release();
		int pulses = 0;
		int last_pulse = -1;
		int n = 0;
		while (cpu_reset === 1'b1 && n < 4 * `A1_CPU_DIV) begin
			if (cpu_clken) begin
				pulses++;
				last_pulse = cycle;
			end
			@(negedge sys_clock);
			n++;
		end
		check_flag(cpu_reset, 1'b0, "cpu_reset release");
		check_count(pulses, `A1_RESET_TICKS, "cpu ticks seen in reset");
		check_count(cycle - last_pulse, 1, "cycles from last tick to release");
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests++;
		if (errors == err_before) begin
			$display("test %0d %s: ok", tests, name);
		end else begin
			failed_tests++;
			$display("test %0d %s: %0d wrong", tests, name, errors - err_before);
		end
	endtask

	initial begin
		int err0;
		int last_pix;
		int last_cpu;
		int first;
		int n;
		a1_addr_t a;
		a1_data_t d;
		void'($urandom(32'haa3));
		{arst_n, pll_locked, reset_request, reset_key, dl_active, dl_wr, cpu_wr} = '0;
		{dl_addr, cpu_addr, dl_data, cpu_dout} = '0;
		{rd_issue, rd_due, errors, tests, failed_tests} = '0;
		foreach (model[i]) model[i] = '0;

		err0 = errors; // test 1 reset state
		@(posedge sys_clock);
		@(posedge sys_clock);
		arst_n <= 1'b1;
		@(negedge sys_clock);
		check_flag(cpu_reset, 1'b1, "cpu_reset after reset");
		check_flag(rom_loaded, 1'b0, "rom_loaded after reset");
		check_flag(cpu_clken, 1'b0, "cpu_clken after reset");
		check_flag(pixel_clken, 1'b0, "pixel_clken after reset");
		finish_test("reset state", err0);

		err0 = errors; // test 2 enable spacing with the release as the previous tick
		last_pix = 0;
		last_cpu = 0;
		while (cycle <= 3 * `A1_CPU_DIV) begin
			if (pixel_clken) begin
				check_count(cycle - last_pix, `A1_PIXEL_DIV, "pixel_clken spacing");
				last_pix = cycle;
			end
			if (cpu_clken) begin
				check_flag(pixel_clken, 1'b1, "pixel_clken beside cpu_clken");
				check_count(cycle - last_cpu, `A1_CPU_DIV, "cpu_clken spacing");
				last_cpu = cycle;
			end
			@(negedge sys_clock);
		end
		check_count(last_cpu, 3 * `A1_CPU_DIV, "cycle of third cpu tick");
		finish_test("enable spacing", err0);

		err0 = errors; // test 3 boot load
		@(posedge sys_clock);
		pll_locked <= 1'b1;
		idle(3);
		dl_active <= 1'b1;
		idle(3);
		for (int i = 0; i < `A1_MONITOR_SIZE; i++) begin
			dl_cycle(a1_addr_t'(`A1_MONITOR_BASE + i), a1_data_t'($urandom));
		end
		for (int i = 0; i < 64; i++) begin
			dl_cycle(a1_addr_t'($urandom % `A1_LOW_RAM_SIZE), a1_data_t'($urandom));
		end
		idle(2);
		dl_active <= 1'b0;
		n = 0;
		while (rom_loaded !== 1'b1 && n < 10) begin
			@(negedge sys_clock);
			n++;
		end
		if (rom_loaded !== 1'b1) begin
			errors++;
			$display("rom_loaded never rose after the download ended");
		end
		measure_release();
		read_back(0);
		finish_test("boot load", err0);

		err0 = errors; // test 4 cpu writes over every region and reads them back
		first = written_q.size();
		repeat (40) begin
			case ($urandom % 5)
				0: a = a1_addr_t'($urandom % `A1_LOW_RAM_SIZE);
				1: a = a1_addr_t'(`A1_BASIC_BASE + $urandom % `A1_BASIC_SIZE);
				2: a = a1_addr_t'(`A1_MONITOR_BASE + $urandom % `A1_MONITOR_SIZE);
				3: a = a1_addr_t'('h4000 + $urandom % 'hA000); // hole below basic
				default: a = a1_addr_t'('hF000 + $urandom % 'hF00); // hole below monitor
			endcase
			cpu_cycle(a, a1_data_t'($urandom), 1'b1);
		end
		read_back(first);
		finish_test("cpu memory", err0);

		err0 = errors; // test 5 collision between cpu and downloader
		a = a1_addr_t'($urandom % `A1_LOW_RAM_SIZE);
		d = a1_data_t'($urandom);
		cpu_cycle(a, d, 1'b1);
		idle(1);
		dl_active <= 1'b1;
		@(negedge sys_clock);
		check_flag(led, 1'b1, "led before collision");
		dl_cycle(a1_addr_t'(`A1_BASIC_BASE + $urandom % `A1_BASIC_SIZE), a1_data_t'($urandom));
		cpu_addr <= a; // later nonblocking writes win, so the cpu writes too
		cpu_dout <= ~d;
		cpu_wr   <= 1'b1;
		@(negedge sys_clock);
		check_flag(led, 1'b0, "led during download write");
		idle(1);
		dl_active <= 1'b0;
		@(negedge sys_clock);
		check_flag(led, 1'b1, "led after collision");
		cpu_cycle(a, '0, 1'b0);
		cpu_cycle(written_q[written_q.size() - 1], '0, 1'b0);
		idle(2);
		finish_test("arbitration", err0);

		err0 = errors; // test 6 reset sources
		@(posedge sys_clock);
		reset_key <= 1'b1;
		@(negedge sys_clock);
		wait_cpu_reset(1'b1, 4);
		measure_release();
		repeat (40) begin
			@(negedge sys_clock);
			check_flag(cpu_reset, 1'b0, "cpu runs with key still held");
		end
		@(posedge sys_clock);
		reset_key     <= 1'b0;
		reset_request <= 1'b1;
		@(negedge sys_clock);
		wait_cpu_reset(1'b1, 4);
		repeat (150) begin
			@(negedge sys_clock);
			check_flag(cpu_reset, 1'b1, "cpu held by reset_request");
		end
		@(posedge sys_clock);
		reset_request <= 1'b0;
		@(negedge sys_clock);
		measure_release();
		read_back(0);
		finish_test("reset sources", err0);

		$display("%0d tests, %0d failed, %0d wrong values", tests, failed_tests, errors);
		if (errors == 0) $display("ALL TESTS PASSED");
		else $display("SOME TESTS FAILED");
		$finish;
	end

	// watchdog at twice the summed test budgets
	initial begin
		#(2 * BUDGET * CLK_PERIOD);
		$display("run timed out after %0d cycles without finishing", 2 * BUDGET);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* tb.f */
+incdir+include
verilog/a1_pkg.sv
verilog/a1_mem_if.sv
verilog/a1_sync_ram.sv
verilog/a1_clock_enables.sv
verilog/a1_boot_fsm.sv
verilog/a1_bus_arbiter.sv
verilog/a1_memory_map.sv
verilog/a1_top.sv
sim/a1_tb.sv

/* Bender.yml */
package:
  name: a1_core

export_include_dirs:
  - include

sources:
  - files:
      - verilog/a1_pkg.sv
      - verilog/a1_mem_if.sv
      - verilog/a1_sync_ram.sv
      - verilog/a1_clock_enables.sv
      - verilog/a1_boot_fsm.sv
      - verilog/a1_bus_arbiter.sv
      - verilog/a1_memory_map.sv
      - verilog/a1_top.sv
  - target: simulation
    files:
      - sim/a1_tb.sv
